/* rtl/afifo_defines.svh */
// sizing of the dual-clock FIFO
// depth is 2**AFIFO_ADDR_W, and the pointers carry one extra wrap bit
// margins are counted in words and must stay below the depth

`ifndef AFIFO_DEFINES_SVH
`define AFIFO_DEFINES_SVH

// stored word width
`define AFIFO_DATA_W        8

// address width, depth 16
`define AFIFO_ADDR_W        4

// almost-full at depth minus this, almost-empty at this or below
`define AFIFO_AFULL_MARGIN  2
`define AFIFO_AEMPTY_MARGIN 2

`endif

/* rtl/afifo_pkg.sv */
// shared types and pointer helpers of the dual-clock FIFO
// widths come from the defines header
// pointer and count types are one bit wider than the address

`include "afifo_defines.svh"

package afifo_pkg;

	typedef logic [`AFIFO_DATA_W-1:0] data_t;
	typedef logic [`AFIFO_ADDR_W-1:0] addr_t;
	typedef logic [`AFIFO_ADDR_W:0]   ptr_t;
	typedef logic [`AFIFO_ADDR_W:0]   gray_t;
	typedef logic [`AFIFO_ADDR_W:0]   cnt_t;

	// what a controller publishes about its own pointer
	typedef struct packed {
		ptr_t  bin;
		gray_t gray;
	} ptr_pair_t;

	function automatic gray_t bin2gray(input ptr_t bin);
		return gray_t'(bin ^ (bin >> 1));
	endfunction

	function automatic ptr_t gray2bin(input gray_t gray);
		ptr_t bin;
		bin[$high(bin)] = gray[$high(gray)];
		for (int i = $high(bin) - 1; i >= 0; i--)
		begin
			bin[i] = bin[i + 1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

/* rtl/afifo_ram.sv */
// simple dual-port storage, one write clock and one read clock
// the read port is registered and loads only on an accepted read
// the array itself has no reset, only the read register does

`timescale 1ns/1ps

module afifo_ram
(
	input  logic             i_wr_clk,
	input  logic             i_rclk,
	input  logic             i_wr_en,
	input  afifo_pkg::addr_t i_wr_addr,
	input  afifo_pkg::data_t i_wr_data,
	input  logic             i_rd_clk,
	input  logic             i_rd_en,
	input  afifo_pkg::addr_t i_rd_addr,
	output afifo_pkg::data_t o_rd_data
);

localparam int depth = 2 ** $bits(afifo_pkg::addr_t);

afifo_pkg::data_t mem [depth];

//////////////////////////////
// write port
//////////////////////////////
always_ff @(posedge i_wr_clk)
begin
	if (i_wr_en)
	begin
		mem[i_wr_addr] <= i_wr_data;
	end
end

//////////////////////////////
// read port
//////////////////////////////
// holds the last word between reads
always_ff @(posedge i_rd_clk or posedge i_rclk)
begin
	if (i_rclk)
		o_rd_data <= '0;
	else if (i_rd_en)
		o_rd_data <= mem[i_rd_addr];
end

endmodule

/* rtl/afifo_ptr_sync.sv */
// brings a Gray pointer into the receiving clock domain
// two flop stages, then Gray back to binary in the receiving domain
// the input must come straight from a register in the sending domain,
// so that only one bit changes per step

`timescale 1ns/1ps

module afifo_ptr_sync
(
	input  logic             i_clk,
	input  logic             i_rclk,
	input  afifo_pkg::gray_t i_gray,
	output afifo_pkg::ptr_t  o_bin
);

// first stage may go metastable
(* async_reg = "true" *) afifo_pkg::gray_t r_sync1;
(* async_reg = "true" *) afifo_pkg::gray_t r_sync2;

//////////////////////////////
// double flop
//////////////////////////////
always_ff @(posedge i_clk or posedge i_rclk)
begin
	if (i_rclk)
	begin
		r_sync1 <= '0;
		r_sync2 <= '0;
	end
	else
	begin
		r_sync1 <= i_gray;
		r_sync2 <= r_sync1;
	end
end

//////////////////////////////
// back to binary
//////////////////////////////
// only this local copy is ever binary, nothing binary crosses
assign o_bin = afifo_pkg::gray2bin(r_sync2);

endmodule

/* rtl/afifo_wr_ctrl.sv */
// write side of the dual-clock FIFO, clocked by i_arst
// i_rclk is the asynchronous active-high reset
// i_rd_ptr must already be synchronized into this clock domain
// full and the count only see reads after the synchronizer delay

`timescale 1ns/1ps

`include "afifo_defines.svh"

module afifo_wr_ctrl
(
	input  logic                 i_arst,
	input  logic                 i_rclk,
	input  logic                 i_we,
	input  afifo_pkg::ptr_t      i_rd_ptr,
	output logic                 o_mem_we,
	output afifo_pkg::addr_t     o_mem_addr,
	output afifo_pkg::ptr_pair_t o_wr_ptr,
	output logic                 o_full,
	output afifo_pkg::cnt_t      o_wcnt,
	output logic                 o_afull
);

localparam afifo_pkg::cnt_t depth = afifo_pkg::cnt_t'(2 ** `AFIFO_ADDR_W);
localparam afifo_pkg::cnt_t afull_level =
	depth - afifo_pkg::cnt_t'(`AFIFO_AFULL_MARGIN);

afifo_pkg::ptr_pair_t r_ptr;
logic                 w_accept;
afifo_pkg::ptr_t      w_bin_next;
afifo_pkg::cnt_t      w_cnt_next;

//////////////////////////////
// accept and next pointer
//////////////////////////////
// writes while full are dropped here
assign w_accept   = i_we & ~o_full;
assign w_bin_next = r_ptr.bin + afifo_pkg::ptr_t'(w_accept);

// the wrap bit makes the modulo difference the true level, 0 to depth
assign w_cnt_next = afifo_pkg::cnt_t'(w_bin_next - i_rd_ptr);

//////////////////////////////
// registered state
//////////////////////////////
always_ff @(posedge i_arst or posedge i_rclk)
begin
	if (i_rclk)
	begin
		r_ptr   <= '0;
		o_full  <= 1'b0;
		o_wcnt  <= '0;
		o_afull <= 1'b0;
	end
	else
	begin
		r_ptr.bin  <= w_bin_next;
		// Gray form leaves from a register, never from logic
		r_ptr.gray <= afifo_pkg::bin2gray(w_bin_next);
		o_full     <= (w_cnt_next == depth);
		o_wcnt     <= w_cnt_next;
		o_afull    <= (w_cnt_next >= afull_level);
	end
end

//////////////////////////////
// memory side
//////////////////////////////
assign o_mem_we   = w_accept;
assign o_mem_addr = r_ptr.bin[`AFIFO_ADDR_W-1:0];
assign o_wr_ptr   = r_ptr;

endmodule

/* rtl/afifo_rd_ctrl.sv */
// read side of the dual-clock FIFO, clocked by i_rd_clk
// i_rclk is the asynchronous active-high reset
// i_wr_ptr must already be synchronized into this clock domain
// empty may stay high for a few edges after data has arrived

`timescale 1ns/1ps

`include "afifo_defines.svh"

module afifo_rd_ctrl
(
	input  logic             i_rd_clk,
	input  logic             i_rclk,
	input  logic             i_re,
	input  afifo_pkg::ptr_t  i_wr_ptr,
	output logic             o_mem_re,
	output afifo_pkg::addr_t o_mem_addr,
	output afifo_pkg::gray_t o_rd_gray,
	output logic             o_empty,
	output afifo_pkg::cnt_t  o_rcnt,
	output logic             o_aempty
);

localparam afifo_pkg::cnt_t aempty_level =
	afifo_pkg::cnt_t'(`AFIFO_AEMPTY_MARGIN);

afifo_pkg::ptr_pair_t r_ptr;
logic                 w_accept;
afifo_pkg::ptr_t      w_bin_next;
afifo_pkg::cnt_t      w_cnt_next;

//////////////////////////////
// accept and next pointer
//////////////////////////////
// reads while empty are dropped here
assign w_accept   = i_re & ~o_empty;
assign w_bin_next = r_ptr.bin + afifo_pkg::ptr_t'(w_accept);

// level left after this edge, as seen from the read side
assign w_cnt_next = afifo_pkg::cnt_t'(i_wr_ptr - w_bin_next);

//////////////////////////////
// registered state
//////////////////////////////
always_ff @(posedge i_rd_clk or posedge i_rclk)
begin
	if (i_rclk)
	begin
		r_ptr    <= '0;
		o_empty  <= 1'b1;
		o_rcnt   <= '0;
		o_aempty <= 1'b1;
	end
	else
	begin
		r_ptr.bin  <= w_bin_next;
		r_ptr.gray <= afifo_pkg::bin2gray(w_bin_next);
		o_empty    <= (w_cnt_next == '0);
		o_rcnt     <= w_cnt_next;
		o_aempty   <= (w_cnt_next <= aempty_level);
	end
end

//////////////////////////////
// memory side
//////////////////////////////
// current address goes out with the strobe, the RAM registers the word
assign o_mem_re   = w_accept;
assign o_mem_addr = r_ptr.bin[`AFIFO_ADDR_W-1:0];

// only the Gray form crosses to the write side
assign o_rd_gray  = r_ptr.gray;

endmodule

/* rtl/afifo_top.sv */
// dual-clock FIFO, 16 words of 8 bits by default
// i_arst is the write clock, i_rd_clk the read clock
// i_rclk is the asynchronous active-high reset for both sides and
// must be held long enough to cover a couple of edges of each clock
// flags are conservative, full and empty release only after sync delay

`timescale 1ns/1ps

`include "afifo_defines.svh"

module afifo_top
(
	input  logic             i_arst,
	input  logic             i_rclk,
	input  logic             i_we,
	input  afifo_pkg::data_t i_wdata,
	input  logic             i_rd_clk,
	input  logic             i_re,
	output afifo_pkg::data_t o_rdata,
	output logic             o_full,
	output logic             o_afull,
	output afifo_pkg::cnt_t  o_wcnt,
	output logic             o_empty,
	output logic             o_aempty,
	output afifo_pkg::cnt_t  o_rcnt
);

// write domain
logic                 w_mem_we;
afifo_pkg::addr_t     w_wr_addr;
afifo_pkg::ptr_pair_t w_wr_ptr;
afifo_pkg::ptr_t      w_rd_ptr_wclk;

// read domain
logic                 w_mem_re;
afifo_pkg::addr_t     w_rd_addr;
afifo_pkg::gray_t     w_rd_gray;
afifo_pkg::ptr_t      w_wr_ptr_rclk;

//////////////////////////////
// write side
//////////////////////////////
afifo_wr_ctrl u_wr_ctrl
(
	.i_arst     (i_arst),
	.i_rclk     (i_rclk),
	.i_we       (i_we),
	.i_rd_ptr   (w_rd_ptr_wclk),
	.o_mem_we   (w_mem_we),
	.o_mem_addr (w_wr_addr),
	.o_wr_ptr   (w_wr_ptr),
	.o_full     (o_full),
	.o_wcnt     (o_wcnt),
	.o_afull    (o_afull)
);

// read pointer into the write domain
afifo_ptr_sync u_rd_ptr_sync
(
	.i_clk  (i_arst),
	.i_rclk (i_rclk),
	.i_gray (w_rd_gray),
	.o_bin  (w_rd_ptr_wclk)
);

//////////////////////////////
// read side
//////////////////////////////
afifo_rd_ctrl u_rd_ctrl
(
	.i_rd_clk   (i_rd_clk),
	.i_rclk     (i_rclk),
	.i_re       (i_re),
	.i_wr_ptr   (w_wr_ptr_rclk),
	.o_mem_re   (w_mem_re),
	.o_mem_addr (w_rd_addr),
	.o_rd_gray  (w_rd_gray),
	.o_empty    (o_empty),
	.o_rcnt     (o_rcnt),
	.o_aempty   (o_aempty)
);

// write pointer into the read domain
afifo_ptr_sync u_wr_ptr_sync
(
	.i_clk  (i_rd_clk),
	.i_rclk (i_rclk),
	.i_gray (w_wr_ptr.gray),
	.o_bin  (w_wr_ptr_rclk)
);

//////////////////////////////
// storage
//////////////////////////////
afifo_ram u_ram
(
	.i_wr_clk  (i_arst),
	.i_rclk    (i_rclk),
	.i_wr_en   (w_mem_we),
	.i_wr_addr (w_wr_addr),
	.i_wr_data (i_wdata),
	.i_rd_clk  (i_rd_clk),
	.i_rd_en   (w_mem_re),
	.i_rd_addr (w_rd_addr),
	.o_rd_data (o_rdata)
);

endmodule

/* verification/afifo_tb.sv */
// testbench for the dual-clock FIFO
// write clock 4 ns, read clock 6 ns, so the edge phases keep drifting
// a queue models the FIFO contents; levels after each row come from the table
// flags are only compared after settling, since they lag across domains

`timescale 1ns/1ps

`include "afifo_defines.svh"

module afifo_tb;

localparam int depth = 2 ** `AFIFO_ADDR_W;
localparam int wait_limit = 400;

typedef enum logic [2:0] {OP_IDLE, OP_WRITE, OP_READ, OP_MIXED, OP_DRAIN} op_t;

// exp_cnt only counts when fixed is set, else the queue size is used
typedef struct packed {
	op_t        op;
	logic [7:0] len;
	logic       fixed;
	logic [4:0] exp_cnt;
} row_t;

logic             i_arst;
logic             i_rclk;
logic             i_we;
afifo_pkg::data_t i_wdata;
logic             i_rd_clk;
logic             i_re;
afifo_pkg::data_t o_rdata;
logic             o_full;
logic             o_afull;
afifo_pkg::cnt_t  o_wcnt;
logic             o_empty;
logic             o_aempty;
afifo_pkg::cnt_t  o_rcnt;

afifo_pkg::data_t model_q [$];
row_t             table_rows [14];
int               errors;
logic [31:0]      wr_lfsr;
logic [31:0]      rd_lfsr;
logic             rd_pending;
afifo_pkg::data_t rd_exp;
afifo_pkg::data_t rd_last;
logic             writer_done;

afifo_top u_afifo_top
(
	.i_arst   (i_arst),
	.i_rclk   (i_rclk),
	.i_we     (i_we),
	.i_wdata  (i_wdata),
	.i_rd_clk (i_rd_clk),
	.i_re     (i_re),
	.o_rdata  (o_rdata),
	.o_full   (o_full),
	.o_afull  (o_afull),
	.o_wcnt   (o_wcnt),
	.o_empty  (o_empty),
	.o_aempty (o_aempty),
	.o_rcnt   (o_rcnt)
);

//////////////////////////////
// clocks
//////////////////////////////
initial
begin
	i_arst = 1'b0;
	forever #2 i_arst = ~i_arst;
end

initial
begin
	i_rd_clk = 1'b0;
	forever #3 i_rd_clk = ~i_rd_clk;
end

//////////////////////////////
// helpers
//////////////////////////////
// Galois form with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic take_bits(inout logic [31:0] st, input int n, output logic [7:0] v);
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		v  = {v[6:0], st[0]};
		st = lfsr_next(st);
	end
endtask

task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
	assert (exp === got)
	else
	begin
		errors++;
		$display("error %s exp %h got %h", name, exp, got);
	end
endtask

// the drive from the previous cycle is accepted or dropped at this edge
task automatic write_cycle(input logic we, input afifo_pkg::data_t d);
	@(posedge i_arst);
	if (i_we && !o_full)
		model_q.push_back(i_wdata);
	i_we    <= we;
	i_wdata <= d;
endtask

task automatic read_cycle(input logic re);
	@(posedge i_rd_clk);
	// o_rdata still shows what the previous edge loaded
	if (rd_pending)
		rd_last = rd_exp;
	compare("o_rdata", rd_last, o_rdata);
	rd_pending = 1'b0;
	if (i_re && !o_empty)
	begin
		assert (model_q.size() > 0)
		else
		begin
			errors++;
			$display("a read was accepted while no word was expected");
		end
		if (model_q.size() > 0)
		begin
			rd_exp     = model_q.pop_front();
			rd_pending = 1'b1;
		end
	end
	i_re <= re;
endtask

task automatic write_burst(input int len);
	logic [7:0] word;
	repeat (len)
	begin
		take_bits(wr_lfsr, 8, word);
		write_cycle(1'b1, word);
	end
endtask

task automatic read_burst(input int len);
	repeat (len)
		read_cycle(1'b1);
endtask

task automatic drain();
	int n;
	n = 0;
	while (model_q.size() != 0 && n < wait_limit)
	begin
		read_cycle(1'b1);
		n++;
	end
	assert (model_q.size() == 0)
	else
	begin
		errors++;
		$display("timeout: the FIFO did not drain, %0d words left", model_q.size());
	end
endtask

task automatic mixed_traffic(input int cycles);
	logic [7:0] we_bit;
	logic [7:0] word;
	logic [7:0] re_bit;
	int         n;
	writer_done = 1'b0;
	n = 0;
	fork
		begin
			repeat (cycles)
			begin
				take_bits(wr_lfsr, 1, we_bit);
				take_bits(wr_lfsr, 8, word);
				write_cycle(we_bit[0], word);
			end
			writer_done = 1'b1;
		end
		begin
			while (!writer_done && n < wait_limit * 4)
			begin
				take_bits(rd_lfsr, 1, re_bit);
				read_cycle(re_bit[0]);
				n++;
			end
			assert (writer_done)
			else
			begin
				errors++;
				$display("timeout: the write traffic did not finish");
			end
		end
	join
endtask

// idle on both clocks until the pointers have crossed
task automatic settle();
	fork
		repeat (8) write_cycle(1'b0, '0);
		repeat (8) read_cycle(1'b0);
	join
endtask

task automatic check_levels(input int level);
	compare("o_wcnt", level, o_wcnt);
	compare("o_rcnt", level, o_rcnt);
	compare("o_full", level == depth, o_full);
	compare("o_empty", level == 0, o_empty);
	compare("o_afull", level >= depth - `AFIFO_AFULL_MARGIN, o_afull);
	compare("o_aempty", level <= `AFIFO_AEMPTY_MARGIN, o_aempty);
endtask

//////////////////////////////
// main sequence
//////////////////////////////
initial
begin
	int level;
	errors      = 0;
	wr_lfsr     = 32'h44f0_7744;
	rd_lfsr     = 32'h44f0_7744;
	rd_pending  = 1'b0;
	rd_exp      = '0;
	rd_last     = '0;
	writer_done = 1'b0;
	i_rclk      = 1'b1;
	i_we        = 1'b0;
	i_wdata     = '0;
	i_re        = 1'b0;

	// op, length, fixed, expected level
	table_rows[0]  = '{OP_IDLE,  8'd0,   1'b1, 5'd0};
	table_rows[1]  = '{OP_WRITE, 8'd10,  1'b1, 5'd10};
	table_rows[2]  = '{OP_READ,  8'd10,  1'b1, 5'd0};
	// overflow drops the last four writes
	table_rows[3]  = '{OP_WRITE, 8'd20,  1'b1, 5'd16};
	table_rows[4]  = '{OP_READ,  8'd16,  1'b1, 5'd0};
	// reads on an empty FIFO leave o_rdata unchanged
	table_rows[5]  = '{OP_READ,  8'd4,   1'b1, 5'd0};
	table_rows[6]  = '{OP_WRITE, 8'd3,   1'b1, 5'd3};
	table_rows[7]  = '{OP_READ,  8'd3,   1'b1, 5'd0};
	table_rows[8]  = '{OP_WRITE, 8'd13,  1'b1, 5'd13};
	table_rows[9]  = '{OP_WRITE, 8'd1,   1'b1, 5'd14};
	table_rows[10] = '{OP_READ,  8'd12,  1'b1, 5'd2};
	table_rows[11] = '{OP_READ,  8'd2,   1'b1, 5'd0};
	table_rows[12] = '{OP_MIXED, 8'd200, 1'b0, 5'd0};
	table_rows[13] = '{OP_DRAIN, 8'd0,   1'b1, 5'd0};

	repeat (2) @(posedge i_arst);
	i_rclk <= 1'b0;
	@(negedge i_rd_clk);

	// reset state
	compare("o_empty", 1, o_empty);
	compare("o_aempty", 1, o_aempty);
	compare("o_full", 0, o_full);
	compare("o_afull", 0, o_afull);
	compare("o_wcnt", 0, o_wcnt);
	compare("o_rcnt", 0, o_rcnt);
	compare("o_rdata", 0, o_rdata);

	for (int r = 0; r < 14; r++)
	begin
		case (table_rows[r].op)
			OP_WRITE: write_burst(table_rows[r].len);
			OP_READ:  read_burst(table_rows[r].len);
			OP_MIXED: mixed_traffic(table_rows[r].len);
			OP_DRAIN: drain();
			default:  ;
		endcase
		settle();
		if (table_rows[r].fixed)
		begin
			level = int'(table_rows[r].exp_cnt);
			compare("model_q size", level, model_q.size());
		end
		else
			level = model_q.size();
		check_levels(level);
	end

	$display("errors: %0d", errors);
	if (errors == 0)
		$display("Test OK");
	else
		$display("Test FAILED");
	$finish;
end

endmodule

/* afifo_top.f */
+incdir+rtl
rtl/afifo_pkg.sv
rtl/afifo_ram.sv
rtl/afifo_ptr_sync.sv
rtl/afifo_wr_ctrl.sv
rtl/afifo_rd_ctrl.sv
rtl/afifo_top.sv
verification/afifo_tb.sv

/* Bender.yml */
package:
  name: afifo

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/afifo_pkg.sv
      - rtl/afifo_ram.sv
      - rtl/afifo_ptr_sync.sv
      - rtl/afifo_wr_ctrl.sv
      - rtl/afifo_rd_ctrl.sv
      - rtl/afifo_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/afifo_tb.sv
